/* common/mipsPkg.sv */
// MIPS decode stage encodings for opcodes, function codes, ALU and control-flow kinds and widths
package mipsPkg;

	// Datapath and register file geometry
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	// JAL writes its return address here
	localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

	// Primary opcode in instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE  = 6'h00,
		OP_REGIMM = 6'h01,
		OP_J      = 6'h02,
		OP_JAL    = 6'h03,
		OP_BEQ    = 6'h04,
		OP_BNE    = 6'h05,
		OP_BLEZ   = 6'h06,
		OP_BGTZ   = 6'h07,
		OP_ADDIU  = 6'h09,
		OP_SLTI   = 6'h0a,
		OP_SLTIU  = 6'h0b,
		OP_ANDI   = 6'h0c,
		OP_ORI    = 6'h0d,
		OP_XORI   = 6'h0e,
		OP_LUI    = 6'h0f,
		OP_COP0   = 6'h10,
		OP_LB     = 6'h20,
		OP_LH     = 6'h21,
		OP_LW     = 6'h23,
		OP_LBU    = 6'h24,
		OP_LHU    = 6'h25,
		OP_SB     = 6'h28,
		OP_SH     = 6'h29,
		OP_SW     = 6'h2b
	} opcodeE;

	// R-type function code in instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_SLLV = 6'h04,
		FN_SRLV = 6'h06,
		FN_SRAV = 6'h07,
		FN_JR   = 6'h08,
		FN_JALR = 6'h09,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} functE;

	// ALU operation with ADD at zero so a cleared register reads as ADD
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		ALU_SRA  = 4'd10,
		ALU_LUI  = 4'd11
	} aluOpE;

	// Control-flow kind resolved in decode
	typedef enum logic [3:0] {
		JB_NONE = 4'd0,
		JB_JUMP = 4'd1,
		JB_JREG = 4'd2,
		JB_BEQ  = 4'd3,
		JB_BNE  = 4'd4,
		JB_BLEZ = 4'd5,
		JB_BGTZ = 4'd6,
		JB_BLTZ = 4'd7,
		JB_BGEZ = 4'd8
	} jumpBranchE;

	// Memory access size and kind with LB doubling as no access
	typedef enum logic [2:0] {
		LS_LB  = 3'd0,
		LS_LH  = 3'd1,
		LS_LW  = 3'd2,
		LS_LBU = 3'd3,
		LS_LHU = 3'd4,
		LS_SB  = 3'd5,
		LS_SH  = 3'd6,
		LS_SW  = 3'd7
	} ldStE;

	// Second ALU operand source
	typedef enum logic [2:0] {
		SRCB_RT      = 3'd0,
		SRCB_RS      = 3'd1,
		SRCB_SEXTIMM = 3'd2,
		SRCB_ZEXTIMM = 3'd3,
		SRCB_ZERO    = 3'd4,
		SRCB_SHAMT   = 3'd5
	} srcBE;

endpackage

/* controlUnit/aluDecoder.sv */
// ALU function decoder mapping opcode and function code to an ALU operation
module aluDecoder import mipsPkg::*; (
	input opcodeE opcode,
	input functE funct,
	output aluOpE aluOp
);

	always_comb begin
		aluOp = ALU_ADD;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_SLL, FN_SLLV: aluOp = ALU_SLL;
					FN_SRL, FN_SRLV: aluOp = ALU_SRL;
					FN_SRA, FN_SRAV: aluOp = ALU_SRA;
					FN_ADDU: aluOp = ALU_ADD;
					FN_SUBU: aluOp = ALU_SUB;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_XOR: aluOp = ALU_XOR;
					FN_NOR: aluOp = ALU_NOR;
					FN_SLT: aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					// JR, JALR and unknown codes
					default: aluOp = ALU_ADD;
				endcase
			end
			OP_ADDIU: aluOp = ALU_ADD;
			OP_SLTI: aluOp = ALU_SLT;
			OP_SLTIU: aluOp = ALU_SLTU;
			OP_ANDI: aluOp = ALU_AND;
			OP_ORI: aluOp = ALU_OR;
			OP_XORI: aluOp = ALU_XOR;
			OP_LUI: aluOp = ALU_LUI;
			// Address generation is base plus offset
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: aluOp = ALU_ADD;
			OP_SB, OP_SH, OP_SW: aluOp = ALU_ADD;
			default: aluOp = ALU_ADD;
		endcase
	end

endmodule

/* controlUnit/controlUnit.sv */
// Main decoder turning an instruction word into the decode stage control signals
module controlUnit import mipsPkg::*; (
	input logic [31:0] instr,
	output aluOpE aluOp,
	output srcBE srcB,
	output logic aluRegSel,
	output logic regDest,
	output logic jalCtrl,
	output logic pcPlus8,
	output logic regWrite,
	output logic memToReg,
	output ldStE ldSt,
	output jumpBranchE jumpBranch
);

	opcodeE opcode;
	functE funct;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;

	assign opcode = opcodeE'(instr[31:26]);
	assign funct = functE'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];

	aluDecoder i_aluDecoder (
		.opcode(opcode),
		.funct(funct),
		.aluOp(aluOp)
	);

	always_comb begin
		// Defaults describe a no-op that unknown opcodes keep
		srcB = SRCB_RT;
		aluRegSel = 1'b0;
		regDest = 1'b0;
		jalCtrl = 1'b0;
		pcPlus8 = 1'b0;
		regWrite = 1'b0;
		memToReg = 1'b0;
		ldSt = LS_LB;
		jumpBranch = JB_NONE;

		case (opcode)
			OP_RTYPE: begin
				regDest = 1'b1;
				regWrite = 1'b1;
				case (funct)
					FN_SLL, FN_SRL, FN_SRA: begin
						srcB = SRCB_SHAMT;
						aluRegSel = 1'b1;
					end
					FN_SLLV, FN_SRLV, FN_SRAV: begin
						srcB = SRCB_RS;
						aluRegSel = 1'b1;
					end
					FN_JR: begin
						regWrite = 1'b0;
						jumpBranch = JB_JREG;
					end
					FN_JALR: begin
						pcPlus8 = 1'b1;
						jumpBranch = JB_JREG;
					end
					default: ;
				endcase
			end

			// Loads write rt from memory
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				srcB = SRCB_SEXTIMM;
				regWrite = 1'b1;
				memToReg = 1'b1;
				case (opcode)
					OP_LH: ldSt = LS_LH;
					OP_LW: ldSt = LS_LW;
					OP_LBU: ldSt = LS_LBU;
					OP_LHU: ldSt = LS_LHU;
					default: ldSt = LS_LB;
				endcase
			end

			OP_SB, OP_SH, OP_SW: begin
				srcB = SRCB_SEXTIMM;
				case (opcode)
					OP_SH: ldSt = LS_SH;
					OP_SW: ldSt = LS_SW;
					default: ldSt = LS_SB;
				endcase
			end

			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				srcB = SRCB_SEXTIMM;
				regWrite = 1'b1;
			end

			// Logical immediates and LUI take the raw 16 bits
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				srcB = SRCB_ZEXTIMM;
				regWrite = 1'b1;
			end

			OP_J: begin
				srcB = SRCB_ZEXTIMM;
				regDest = 1'b1;
				jumpBranch = JB_JUMP;
			end

			OP_JAL: begin
				srcB = SRCB_ZEXTIMM;
				regDest = 1'b1;
				jalCtrl = 1'b1;
				pcPlus8 = 1'b1;
				regWrite = 1'b1;
				jumpBranch = JB_JUMP;
			end

			OP_BEQ, OP_BNE: begin
				regDest = 1'b1;
				jumpBranch = (opcode == OP_BEQ) ? JB_BEQ : JB_BNE;
			end

			OP_BLEZ, OP_BGTZ: begin
				srcB = SRCB_ZERO;
				regDest = 1'b1;
				jumpBranch = (opcode == OP_BLEZ) ? JB_BLEZ : JB_BGTZ;
			end

			// rt selects between BLTZ and BGEZ
			OP_REGIMM: begin
				srcB = SRCB_ZERO;
				regDest = 1'b1;
				jumpBranch = (rt == '0) ? JB_BLTZ : JB_BGEZ;
			end

			// MFC has rs zero and writes a GPR while MTC does not
			OP_COP0: begin
				aluRegSel = 1'b1;
				regWrite = (rs == '0);
			end

			default: ;
		endcase
	end

endmodule

/* mipsDecode.f */
common/mipsPkg.sv
controlUnit/aluDecoder.sv
controlUnit/controlUnit.sv
verilog/branchResolver.sv
verilog/idExRegister.sv
verilog/decodeStage.sv
verification/decodeStageTb.sv

/* verification/decodeStageTb.sv */
// Testbench for the decode stage replaying hex vectors and checking redirect and ID/EX outputs
module decodeStageTb import mipsPkg::*; ();

	localparam logic [31:0] resetPc = 32'hbfc0_0000;
	localparam int wordsPerVec = 8;
	localparam int maxVecs = 64;

	logic clk;
	logic rstN;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] rsValue;
	logic [31:0] rtValue;
	logic stall;
	logic flush;
	logic redirect;
	logic [31:0] redirectTarget;
	aluOpE exAluOp;
	logic exAluRegSel;
	logic exRegWrite;
	logic exMemToReg;
	ldStE exLdSt;
	logic exPcPlus8;
	logic [4:0] exWriteReg;
	logic [31:0] exOperandA;
	logic [31:0] exOperandB;
	logic [31:0] exPc;

	// Word 0 is the vector count, then eight words per vector
	logic [31:0] vecMem [0:maxVecs*wordsPerVec];
	int vecCount = 0;
	int cycleCount = 0;
	int testErrors = 0;
	int passCount = 0;
	int failCount = 0;
	string testLabel;

	decodeStage #(
		.resetPc(resetPc)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.stall(stall),
		.flush(flush),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.exAluOp(exAluOp),
		.exAluRegSel(exAluRegSel),
		.exRegWrite(exRegWrite),
		.exMemToReg(exMemToReg),
		.exLdSt(exLdSt),
		.exPcPlus8(exPcPlus8),
		.exWriteReg(exWriteReg),
		.exOperandA(exOperandA),
		.exOperandB(exOperandB),
		.exPc(exPc)
	);

	always #50 clk = ~clk;

	// Watchdog limit follows the number of vectors
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= vecCount + 20) begin
			$display("error: run did not finish within %0d clock cycles", vecCount + 20);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("mismatch %s %s expected %h actual %h", testLabel, name, expected, actual);
		testErrors++;
	endtask

	task automatic recordResult();
		if (testErrors == 0) begin
			passCount++;
			$display("%s ok", testLabel);
		end else begin
			failCount++;
			$display("%s failed with %0d errors", testLabel, testErrors);
		end
	endtask

	initial begin
		logic [31:0] ctrl;
		logic [31:0] expFlags;
		logic [31:0] expOpB;
		logic [31:0] expOpA;
		logic [31:0] expPc;
		int base;
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		pc = '0;
		rsValue = '0;
		rtValue = '0;
		stall = 1'b0;
		flush = 1'b0;
		expOpA = '0;
		expPc = resetPc;
		$readmemh("verification/decodeStimulus.hex", vecMem);
		vecCount = vecMem[0];
		if (vecCount < 1 || vecCount > maxVecs) begin
			$display("error: stimulus file gave %0d vectors, 1 to %0d allowed", vecCount, maxVecs);
			failCount++;
			vecCount = 0;
		end

		// Reset values are visible before the first vector is accepted
		repeat (5) @(negedge clk);
		testLabel = "reset";
		testErrors = 0;
		if (exRegWrite !== 1'b0) reportMismatch("exRegWrite", 32'd0, exRegWrite);
		if (exMemToReg !== 1'b0) reportMismatch("exMemToReg", 32'd0, exMemToReg);
		if (exPcPlus8 !== 1'b0) reportMismatch("exPcPlus8", 32'd0, exPcPlus8);
		if (exPc !== resetPc) reportMismatch("exPc", resetPc, exPc);
		recordResult();
		rstN = 1'b1;

		for (int k = 0; k < vecCount; k++) begin
			base = 1 + k * wordsPerVec;
			ctrl = vecMem[base + 4];
			instr = vecMem[base];
			pc = vecMem[base + 1];
			rsValue = vecMem[base + 2];
			rtValue = vecMem[base + 3];
			stall = ctrl[8];
			flush = ctrl[4];
			testLabel = $sformatf("vector %0d", k);
			testErrors = 0;
			// Sample just ahead of the rising edge
			#40;
			if (redirect !== ctrl[0]) reportMismatch("redirect", ctrl[0], redirect);
			if (ctrl[0] && redirectTarget !== vecMem[base + 5])
				reportMismatch("redirectTarget", vecMem[base + 5], redirectTarget);
			@(negedge clk);
			expFlags = vecMem[base + 6];
			expOpB = vecMem[base + 7];
			// Operand A is rt for shifts and rs otherwise, cleared in a bubble
			if (!ctrl[8]) begin
				expPc = vecMem[base + 1];
				if (ctrl[4])
					expOpA = '0;
				else if (expFlags[15:12] == ALU_SLL || expFlags[15:12] == ALU_SRL ||
					expFlags[15:12] == ALU_SRA)
					expOpA = vecMem[base + 3];
				else
					expOpA = vecMem[base + 2];
			end
			if (exRegWrite !== expFlags[28]) reportMismatch("exRegWrite", expFlags[28], exRegWrite);
			if (exMemToReg !== expFlags[24]) reportMismatch("exMemToReg", expFlags[24], exMemToReg);
			if (exPcPlus8 !== expFlags[20]) reportMismatch("exPcPlus8", expFlags[20], exPcPlus8);
			if (exAluRegSel !== expFlags[16])
				reportMismatch("exAluRegSel", expFlags[16], exAluRegSel);
			if (exAluOp !== expFlags[15:12]) reportMismatch("exAluOp", expFlags[15:12], exAluOp);
			if (exLdSt !== expFlags[10:8]) reportMismatch("exLdSt", expFlags[10:8], exLdSt);
			if (exWriteReg !== expFlags[4:0]) reportMismatch("exWriteReg", expFlags[4:0], exWriteReg);
			if (exOperandA !== expOpA) reportMismatch("exOperandA", expOpA, exOperandA);
			if (exOperandB !== expOpB) reportMismatch("exOperandB", expOpB, exOperandB);
			if (exPc !== expPc) reportMismatch("exPc", expPc, exPc);
			recordResult();
		end

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* verification/decodeStimulus.hex */
// instr pc rsValue rtValue ctrl(stall,flush,redirect nibbles) target ex(rw,mr,p8,ars,alu,ls,wr) opB
// First word is the vector count, ex fields are checked one cycle after the vector is driven
00000036
00221821 00400000 00000010 00000020 00000000 00000000 10000003 00000020 // addu
00221823 00400004 00000010 00000020 00000000 00000000 10001003 00000020 // subu
00221824 00400008 00000010 00000020 00000000 00000000 10002003 00000020 // and
00221825 0040000c 00000010 00000020 00000000 00000000 10003003 00000020 // or
00221826 00400010 00000010 00000020 00000000 00000000 10004003 00000020 // xor
00221827 00400014 00000010 00000020 00000000 00000000 10005003 00000020 // nor
0022182a 00400018 00000010 00000020 00000000 00000000 10006003 00000020 // slt
0022182b 0040001c 00000010 00000020 00000000 00000000 10007003 00000020 // sltu
00021900 00400020 00000010 00000020 00000000 00000000 10018003 00000004 // sll 4
00021fc3 00400024 00000010 00000020 00000000 00000000 1001a003 0000001f // sra 31
00221806 00400028 00000010 00000020 00000000 00000000 10019003 00000010 // srlv
8022fffc 0040002c 00000010 00000020 00000000 00000000 11000002 fffffffc // lb
84220008 00400030 00000010 00000020 00000000 00000000 11000102 00000008 // lh
8c228000 00400034 00000010 00000020 00000000 00000000 11000202 ffff8000 // lw
90227fff 00400038 00000010 00000020 00000000 00000000 11000302 00007fff // lbu
94220002 0040003c 00000010 00000020 00000000 00000000 11000402 00000002 // lhu
a022fff0 00400040 00000010 00000020 00000000 00000000 00000502 fffffff0 // sb
a4220004 00400044 00000010 00000020 00000000 00000000 00000602 00000004 // sh
ac228004 00400048 00000010 00000020 00000000 00000000 00000702 ffff8004 // sw
24228001 0040004c 00000010 00000020 00000000 00000000 10000002 ffff8001 // addiu
2822ffff 00400050 00000010 00000020 00000000 00000000 10006002 ffffffff // slti
2c220010 00400054 00000010 00000020 00000000 00000000 10007002 00000010 // sltiu
3022ff00 00400058 00000010 00000020 00000000 00000000 10002002 0000ff00 // andi
34228000 0040005c 00000010 00000020 00000000 00000000 10003002 00008000 // ori
3822f0f0 00400060 00000010 00000020 00000000 00000000 10004002 0000f0f0 // xori
3c021234 00400064 00000010 00000020 00000000 00000000 1000b002 00001234 // lui
40026000 00400068 00000010 00000020 00000000 00000000 10010002 00000020 // mfc
40826000 0040006c 00000010 00000020 00000000 00000000 00010002 00000020 // mtc
fc221234 00400070 00000010 00000020 00000000 00000000 00000002 00000020 // unknown opcode
10220010 00400074 00000055 00000055 00000001 004000b8 00000000 00000055 // beq equal
1022fff0 00400078 00000055 00000056 00000000 0040003c 0000001f 00000056 // beq unequal
1422fff0 0040007c 00000055 00000056 00000001 00400040 0000001f 00000056 // bne unequal
14220010 00400080 00000077 00000077 00000000 004000c4 00000000 00000077 // bne equal
18200010 00400084 ffffffff 00000000 00000001 004000c8 00000000 00000000 // blez negative
18200010 00400088 00000000 00000000 00000001 004000cc 00000000 00000000 // blez zero
18200010 0040008c 00000001 00000000 00000000 004000d0 00000000 00000000 // blez positive
1c200010 00400090 80000000 00000000 00000000 004000d4 00000000 00000000 // bgtz negative
1c200010 00400094 00000000 00000000 00000000 004000d8 00000000 00000000 // bgtz zero
1c200010 00400098 7fffffff 00000000 00000001 004000dc 00000000 00000000 // bgtz positive
0420fff0 0040009c fffffff0 00000000 00000001 00400060 0000001f 00000000 // bltz negative
0420fff0 004000a0 00000000 00000000 00000000 00400064 0000001f 00000000 // bltz zero
0420fff0 004000a4 00000010 00000000 00000000 00400068 0000001f 00000000 // bltz positive
0421fff0 004000a8 80000000 00000000 00000000 0040006c 0000001f 00000000 // bgez negative
0421fff0 004000ac 00000000 00000000 00000001 00400070 0000001f 00000000 // bgez zero
0421fff0 004000b0 00000001 00000000 00000001 00400074 0000001f 00000000 // bgez positive
08123456 90000ffc 00000010 00000020 00000001 9048d158 00000006 00003456 // j
0c123456 a0000000 00000010 00000020 00000001 a048d158 1010001f 00003456 // jal
00200008 004000bc 00401234 0000abcd 00000001 00401234 00000000 0000abcd // jr
0020f809 004000c0 00402000 00000000 00000001 00402000 1010001f 00000000 // jalr
10220010 004000c4 00000005 00000005 00000100 00000000 1010001f 00000000 // stall, beq held
00200008 004000c8 00001000 00000000 00000110 00000000 1010001f 00000000 // stall and flush, jr
8c228000 004000cc 00000010 00000020 00000010 00000000 00000000 00000000 // flush lw
1422fff0 004000d0 00000001 00000002 00000010 00000000 00000000 00000000 // flush bne
00221821 004000d4 00000001 00000002 00000000 00000000 10000003 00000002 // addu after flush

/* verilog/branchResolver.sv */
// Branch and jump resolver steering fetch from the decode stage
module branchResolver import mipsPkg::*; (
	input jumpBranchE jumpBranch,
	input logic [31:0] instr,
	input logic [31:0] pc,
	input logic [31:0] rsValue,
	input logic [31:0] rtValue,
	input logic stall,
	input logic flush,
	output logic redirect,
	output logic [31:0] redirectTarget
);

	logic [31:0] pcPlus4;
	logic [31:0] branchOffset;
	logic rsNeg;
	logic rsZero;
	logic taken;

	assign pcPlus4 = pc + 32'd4;
	assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};

	// Signed compare of rs against zero
	assign rsNeg = $signed(rsValue) < 0;
	assign rsZero = (rsValue == '0);

	always_comb begin
		case (jumpBranch)
			JB_JUMP, JB_JREG: taken = 1'b1;
			JB_BEQ: taken = (rsValue == rtValue);
			JB_BNE: taken = (rsValue != rtValue);
			JB_BLEZ: taken = rsNeg | rsZero;
			JB_BGTZ: taken = !rsNeg && !rsZero;
			JB_BLTZ: taken = rsNeg;
			JB_BGEZ: taken = !rsNeg;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (jumpBranch)
			// Region of the delay slot plus the word index
			JB_JUMP: redirectTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
			JB_JREG: redirectTarget = rsValue;
			default: redirectTarget = pcPlus4 + branchOffset;
		endcase
	end

	// A held or killed instruction must not steer fetch
	assign redirect = taken && !stall && !flush;

endmodule

/* verilog/decodeStage.sv */
// Instruction decode stage top level joining control, branch resolution and the ID/EX register
module decodeStage import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input logic clk,
	input logic rstN,
	input logic [31:0] instr,
	input logic [31:0] pc,
	input logic [dataWidth-1:0] rsValue,
	input logic [dataWidth-1:0] rtValue,
	input logic stall,
	input logic flush,
	output logic redirect,
	output logic [31:0] redirectTarget,
	output aluOpE exAluOp,
	output logic exAluRegSel,
	output logic exRegWrite,
	output logic exMemToReg,
	output ldStE exLdSt,
	output logic exPcPlus8,
	output logic [regAddrWidth-1:0] exWriteReg,
	output logic [dataWidth-1:0] exOperandA,
	output logic [dataWidth-1:0] exOperandB,
	output logic [31:0] exPc
);

	aluOpE aluOp;
	srcBE srcB;
	logic aluRegSel;
	logic regDest;
	logic jalCtrl;
	logic pcPlus8;
	logic regWrite;
	logic memToReg;
	ldStE ldSt;
	jumpBranchE jumpBranch;

	controlUnit i_controlUnit (
		.instr(instr),
		.aluOp(aluOp),
		.srcB(srcB),
		.aluRegSel(aluRegSel),
		.regDest(regDest),
		.jalCtrl(jalCtrl),
		.pcPlus8(pcPlus8),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.ldSt(ldSt),
		.jumpBranch(jumpBranch)
	);

	// Redirect is resolved in the same cycle
	branchResolver i_branchResolver (
		.jumpBranch(jumpBranch),
		.instr(instr),
		.pc(pc),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.stall(stall),
		.flush(flush),
		.redirect(redirect),
		.redirectTarget(redirectTarget)
	);

	idExRegister #(
		.resetPc(resetPc)
	) i_idExRegister (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.flush(flush),
		.instr(instr),
		.pc(pc),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.aluOp(aluOp),
		.srcB(srcB),
		.aluRegSel(aluRegSel),
		.regDest(regDest),
		.jalCtrl(jalCtrl),
		.pcPlus8(pcPlus8),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.ldSt(ldSt),
		.exAluOp(exAluOp),
		.exAluRegSel(exAluRegSel),
		.exRegWrite(exRegWrite),
		.exMemToReg(exMemToReg),
		.exLdSt(exLdSt),
		.exPcPlus8(exPcPlus8),
		.exWriteReg(exWriteReg),
		.exOperandA(exOperandA),
		.exOperandB(exOperandB),
		.exPc(exPc)
	);

endmodule

/* verilog/idExRegister.sv */
// ID/EX pipeline register with operand and destination select, stall hold and flush bubble
module idExRegister import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input logic [31:0] instr,
	input logic [31:0] pc,
	input logic [dataWidth-1:0] rsValue,
	input logic [dataWidth-1:0] rtValue,
	input aluOpE aluOp,
	input srcBE srcB,
	input logic aluRegSel,
	input logic regDest,
	input logic jalCtrl,
	input logic pcPlus8,
	input logic regWrite,
	input logic memToReg,
	input ldStE ldSt,
	output aluOpE exAluOp,
	output logic exAluRegSel,
	output logic exRegWrite,
	output logic exMemToReg,
	output ldStE exLdSt,
	output logic exPcPlus8,
	output logic [regAddrWidth-1:0] exWriteReg,
	output logic [dataWidth-1:0] exOperandA,
	output logic [dataWidth-1:0] exOperandB,
	output logic [31:0] exPc
);

	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	logic [regAddrWidth-1:0] writeReg;
	logic isShift;

	// Shifts put rs or shamt on B, so the shifted value rt goes on A
	assign isShift = (srcB == SRCB_SHAMT) || (srcB == SRCB_RS);
	assign operandA = isShift ? rtValue : rsValue;

	always_comb begin
		case (srcB)
			SRCB_RT: operandB = rtValue;
			SRCB_RS: operandB = rsValue;
			SRCB_SEXTIMM: operandB = {{(dataWidth-16){instr[15]}}, instr[15:0]};
			SRCB_ZEXTIMM: operandB = {{(dataWidth-16){1'b0}}, instr[15:0]};
			SRCB_SHAMT: operandB = {{(dataWidth-5){1'b0}}, instr[10:6]};
			default: operandB = '0;
		endcase
	end

	// JAL link register first, then rd for R-type style, else rt
	assign writeReg = jalCtrl ? linkReg : (regDest ? instr[15:11] : instr[20:16]);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exAluOp <= ALU_ADD;
			exAluRegSel <= 1'b0;
			exRegWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exLdSt <= LS_LB;
			exPcPlus8 <= 1'b0;
			exWriteReg <= '0;
			exOperandA <= '0;
			exOperandB <= '0;
			exPc <= resetPc;
		end else if (stall) begin
			// Stall wins over flush and holds everything
		end else if (flush) begin
			// Bubble that neither writes a register nor touches memory
			exAluOp <= ALU_ADD;
			exAluRegSel <= 1'b0;
			exRegWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exLdSt <= LS_LB;
			exPcPlus8 <= 1'b0;
			exWriteReg <= '0;
			exOperandA <= '0;
			exOperandB <= '0;
			exPc <= pc;
		end else begin
			exAluOp <= aluOp;
			exAluRegSel <= aluRegSel;
			exRegWrite <= regWrite;
			exMemToReg <= memToReg;
			exLdSt <= ldSt;
			exPcPlus8 <= pcPlus8;
			exWriteReg <= writeReg;
			exOperandA <= operandA;
			exOperandB <= operandB;
			exPc <= pc;
		end
	end

	// A flushed slot reaches execute without any write side effect
	assert property (@(posedge clk) disable iff (!rstN)
		(flush && !stall) |=> (!exRegWrite && !exMemToReg));

	// Stalled cycle leaves the whole register untouched
	assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable({exAluOp, exAluRegSel, exRegWrite, exMemToReg, exLdSt,
			exPcPlus8, exWriteReg, exOperandA, exOperandB, exPc}));

endmodule
